// ==== files.f ====
+incdir+src
src/ooo_pkg.sv
src/instr_axil_slave.sv
src/issue_control.sv
src/reg_status_file.sv
src/alu_stations.sv
src/reorder_buffer.sv
src/ooo_issue_top.sv
verification/ooo_issue_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= ooo_issue_tb
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT ?= TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/ooo_issue_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ooo_consts.svh"

module ooo_issue_tb;

	import ooo_pkg::*;

	localparam int clk_period = 4;
	localparam int num_directed = 10;
	localparam int num_random = 40;
	localparam int num_entries = num_directed + num_random;
	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	logic clk, reset;
	logic awvalid, wvalid, bready, retire_ready;
	logic [31:0] awaddr;
	lc3b_word wdata;
	logic awready, wready, bvalid, retire_valid;
	logic [1:0] bresp;
	retire_t retire;

	// Stimulus table and expected retire order
	lc3b_word tbl_instr [num_entries];
	logic [1:0] tbl_resp [num_entries];
	retire_t exp_retires [$];
	lc3b_word ref_regs [`OOO_NUM_REGS]; // Reference register model

	integer seed;
	int resp_errors, retire_errors, other_errors;
	int stall_left;

	ooo_issue_top dut_i (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#(clk_period / 2) clk = ~clk;
	end

	function automatic lc3b_word encode(input lc3b_opcode op, input lc3b_reg dr,
		input lc3b_reg sr1, input logic imm, input logic [4:0] low5);
		return {op, dr, sr1, imm, low5};
	endfunction

	function automatic lc3b_word random_word();
		logic [31:0] r;
		lc3b_opcode op;
		logic imm;
		logic [4:0] low5;
		lc3b_word word;
		r = $random(seed);
		imm = r[11];
		low5 = imm ? r[26:22] : {2'b00, r[24:22]};
		op = (r[9:8] == 2'd3) ? op_not : (r[8] ? op_and : op_add);
		word = encode(op, r[18:16], r[21:19], imm, low5);
		if (op == op_not)
			word[5:0] = 6'h3f;
		if (r[3:0] == 4'h0)
		begin
			// Opcode outside the executed set
			op = lc3b_opcode'(r[7:4]);
			if (op == op_add || op == op_and || op == op_not)
				op = op_lea;
			word = {op, r[27:16]};
		end
		return word;
	endfunction

	// LC-3b ADD, AND and NOT with 16-bit wrap
	task automatic add_entry(input int idx, input lc3b_word word);
		lc3b_opcode op;
		lc3b_word a, b, result;
		retire_t rec;
		op = lc3b_opcode'(word[15:12]);
		tbl_instr[idx] = word;
		if (op != op_add && op != op_and && op != op_not)
			tbl_resp[idx] = resp_slverr; // Refused, never retires
		else
		begin
			a = ref_regs[word[8:6]];
			b = word[5] ? {{11{word[4]}}, word[4:0]} : ref_regs[word[2:0]];
			case (op)
				op_add: result = a + b;
				op_and: result = a & b;
				default: result = ~a;
			endcase
			ref_regs[word[11:9]] = result;
			rec.dest = word[11:9];
			rec.value = result;
			exp_retires.push_back(rec);
			tbl_resp[idx] = resp_okay;
		end
	endtask

	task automatic build_table();
		for (int r = 0; r < `OOO_NUM_REGS; r++)
			ref_regs[r] = '0;
		add_entry(0, encode(op_add, 3'd1, 3'd0, 1'b1, 5'd5));
		add_entry(1, encode(op_add, 3'd2, 3'd1, 1'b1, 5'h1d)); // Minus 3
		add_entry(2, encode(op_add, 3'd3, 3'd1, 1'b0, 5'd2));
		add_entry(3, encode(op_not, 3'd4, 3'd3, 1'b1, 5'h1f));
		add_entry(4, 16'h2000); // LDB
		add_entry(5, encode(op_and, 3'd5, 3'd4, 1'b1, 5'd15));
		add_entry(6, encode(op_add, 3'd5, 3'd5, 1'b0, 5'd5));
		add_entry(7, encode(op_add, 3'd6, 3'd5, 1'b0, 5'd4)); // Wraps past 16 bits
		add_entry(8, 16'hf025); // TRAP
		add_entry(9, encode(op_not, 3'd1, 3'd1, 1'b1, 5'h1f));
		for (int i = num_directed; i < num_entries; i++)
			add_entry(i, random_word());
	endtask

	task automatic check_resp(input int idx, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
		begin
			$display("Error: bresp entry %0d got %h expected %h", idx, got, exp);
			resp_errors++;
		end
	endtask

	task automatic check_retire(input retire_t got, input retire_t exp);
		if (got !== exp)
		begin
			$display("Error: retire got dest %h value %h expected dest %h value %h",
				got.dest, got.value, exp.dest, exp.value);
			retire_errors++;
		end
	endtask

	// Called on a falling edge, returns on the falling edge after the response
	task automatic axi_write(input int idx);
		awvalid = 1'b1;
		wvalid = 1'b1;
		awaddr = 32'(idx) << 1;
		wdata = tbl_instr[idx];
		@(negedge clk);
		while (!awready)
			@(negedge clk);
		if (wready !== 1'b1)
		begin
			$display("Error: wready %h expected %h with awready high", wready, 1'b1);
			other_errors++;
		end
		@(negedge clk); // Handshake on the rising edge in between
		awvalid = 1'b0;
		wvalid = 1'b0;
		if (awready || wready)
		begin
			$display("Error: awready %h wready %h expected 0 after the handshake",
				awready, wready);
			other_errors++;
		end
		if (bvalid)
			check_resp(idx, bresp, tbl_resp[idx]);
		else
		begin
			$display("No write response for entry %0d one cycle after the handshake", idx);
			other_errors++;
		end
	endtask

	// Mostly ready, with occasional long stalls to fill the ROB and the queue
	task automatic drive_retire_ready();
		logic [31:0] r;
		r = $random(seed);
		if (stall_left > 0)
		begin
			retire_ready = 1'b0;
			stall_left--;
		end
		else if (r[4:0] == 5'd0)
		begin
			retire_ready = 1'b0;
			stall_left = 16 + 2 * int'(r[8:5]);
		end
		else
			retire_ready = r[0] | r[1];
	endtask

	// Retire monitor
	initial
	begin
		retire_t exp_rec;
		stall_left = 0;
		wait (!reset);
		forever
		begin
			@(negedge clk);
			drive_retire_ready();
			if (retire_valid && retire_ready)
			begin
				if (exp_retires.size() == 0)
				begin
					$display("Unexpected retire of dest %h value %h with nothing outstanding",
						retire.dest, retire.value);
					other_errors++;
				end
				else
				begin
					exp_rec = exp_retires.pop_front();
					check_retire(retire, exp_rec);
				end
			end
		end
	end

	initial
	begin
		repeat (num_entries * 40 + 4) @(posedge clk);
		$display("Timeout, writes or retires did not complete in %0d cycles", num_entries * 40);
		$display("Errors: bresp %0d, retire %0d, other %0d",
			resp_errors, retire_errors, other_errors + 1);
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		seed = 32'h847c5644;
		resp_errors = 0;
		retire_errors = 0;
		other_errors = 0;
		reset = 1'b1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		awaddr = '0;
		wdata = '0;
		bready = 1'b0;
		retire_ready = 1'b0;
		build_table();
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		if (awready || wready || bvalid || retire_valid)
		begin
			$display("Error: after reset awready %h wready %h bvalid %h retire_valid %h",
				awready, wready, bvalid, retire_valid);
			other_errors++;
		end
		bready = 1'b1;
		for (int i = 0; i < num_entries; i++)
			axi_write(i);
		while (exp_retires.size() != 0)
			@(negedge clk);
		repeat (20) @(negedge clk); // Room for a stray retire to show up
		if (retire_valid)
		begin
			$display("Retire still pending after the last expected record");
			other_errors++;
		end
		$display("Errors: bresp %0d, retire %0d, other %0d",
			resp_errors, retire_errors, other_errors);
		if (resp_errors + retire_errors + other_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule : ooo_issue_tb

`default_nettype wire

// ==== src/ooo_issue_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ooo_consts.svh"

module ooo_issue_top
(
	input logic clk,
	input logic reset,
	input logic awvalid,
	input logic [31:0] awaddr,
	input logic wvalid,
	input ooo_pkg::lc3b_word wdata,
	output logic awready,
	output logic wready,
	output logic bvalid,
	output logic [1:0] bresp,
	input logic bready,
	output logic retire_valid,
	output ooo_pkg::retire_t retire,
	input logic retire_ready
);

	import ooo_pkg::*;

	lc3b_word instr;
	logic instr_valid, instr_taken;
	cdb_t cdb;
	reg_status_t sr1_status, sr2_status;
	lc3b_reg sr1, sr2, reg_dest;
	logic ld_reg_busy_dest;
	lc3b_rob_addr reg_rob_entry, rob_sr1_read_addr, rob_sr2_read_addr, rob_addr, retire_tag;
	lc3b_word rob_sr1_value_out, rob_sr2_value_out;
	logic rob_sr1_valid_out, rob_sr2_valid_out, rob_full, rob_write_enable;
	rob_alloc_t rob_alloc;
	logic [`OOO_NUM_STATIONS-1:0] station_busy, station_sel;
	logic station_write;
	station_issue_t station_issue;

	instr_axil_slave axil_i (.*);

	issue_control issue_i
	(
		.*,
		.cdb_in(cdb),
		.sr1_in(sr1_status),
		.sr2_in(sr2_status)
	);

	reg_status_file regs_i
	(
		.*,
		.sr1_out(sr1_status),
		.sr2_out(sr2_status),
		.commit_valid(retire_valid && retire_ready), // Retire handshake
		.commit(retire),
		.commit_tag(retire_tag)
	);

	alu_stations stations_i (.*, .cdb_out(cdb));

	reorder_buffer rob_i (.*, .cdb_in(cdb));

endmodule : ooo_issue_top

`default_nettype wire

// ==== src/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ooo_consts.svh"

module reorder_buffer
(
	input logic clk,
	input logic reset,
	input logic rob_write_enable,
	input ooo_pkg::rob_alloc_t rob_alloc,
	output ooo_pkg::lc3b_rob_addr rob_addr,
	output logic rob_full,
	input ooo_pkg::cdb_t cdb_in,
	input ooo_pkg::lc3b_rob_addr rob_sr1_read_addr,
	input ooo_pkg::lc3b_rob_addr rob_sr2_read_addr,
	output ooo_pkg::lc3b_word rob_sr1_value_out,
	output ooo_pkg::lc3b_word rob_sr2_value_out,
	output logic rob_sr1_valid_out,
	output logic rob_sr2_valid_out,
	output logic retire_valid,
	output ooo_pkg::retire_t retire,
	output ooo_pkg::lc3b_rob_addr retire_tag,
	input logic retire_ready
);

	import ooo_pkg::*;

	localparam logic [`OOO_TAG_WIDTH:0] rob_depth = `OOO_ROB_DEPTH;

	logic [`OOO_ROB_DEPTH-1:0] done;
	lc3b_reg dest [`OOO_ROB_DEPTH];
	lc3b_word value [`OOO_ROB_DEPTH];
	lc3b_rob_addr head, tail;
	logic [`OOO_TAG_WIDTH:0] count;
	logic retire_fire;

	assign rob_addr = tail; // Tag for the next issue
	assign rob_full = (count == rob_depth);

	// Operand lookups for issue
	assign rob_sr1_value_out = value[rob_sr1_read_addr];
	assign rob_sr2_value_out = value[rob_sr2_read_addr];
	assign rob_sr1_valid_out = done[rob_sr1_read_addr];
	assign rob_sr2_valid_out = done[rob_sr2_read_addr];

	assign retire_valid = (count != '0) && done[head];
	assign retire = '{dest: dest[head], value: value[head]};
	assign retire_tag = head;
	assign retire_fire = retire_valid && retire_ready;

	always_ff @(posedge clk)
	begin
		if (rob_write_enable)
			dest[tail] <= rob_alloc.dest;
		if (cdb_in.valid)
			value[cdb_in.tag] <= cdb_in.data;
		if (reset)
		begin
			done <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else
		begin
			if (rob_write_enable)
			begin
				done[tail] <= 1'b0;
				tail <= tail + 1'b1;
			end
			if (cdb_in.valid)
				done[cdb_in.tag] <= 1'b1;
			if (retire_fire)
				head <= head + 1'b1;
			case ({rob_write_enable, retire_fire})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule : reorder_buffer

`default_nettype wire

// ==== src/alu_stations.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ooo_consts.svh"

module alu_stations
(
	input logic clk,
	input logic reset,
	input logic station_write,
	input logic [`OOO_NUM_STATIONS-1:0] station_sel,
	input ooo_pkg::station_issue_t station_issue,
	output logic [`OOO_NUM_STATIONS-1:0] station_busy,
	output ooo_pkg::cdb_t cdb_out
);

	import ooo_pkg::*;

	localparam int idx_width = $clog2(`OOO_NUM_STATIONS);

	station_issue_t stations [`OOO_NUM_STATIONS];
	logic [`OOO_NUM_STATIONS-1:0] busy, ready;
	logic [idx_width-1:0] exec_idx;
	logic any_ready;

	function automatic lc3b_word alu(input station_issue_t s);
		case (s.op)
			op_add: return s.vj + s.vk;
			op_and: return s.vj & s.vk;
			default: return ~s.vj; // NOT
		endcase
	endfunction

	// Lowest ready index wins the CDB
	always_comb
	begin
		exec_idx = '0;
		for (int i = `OOO_NUM_STATIONS - 1; i >= 0; i--)
		begin
			ready[i] = busy[i] && stations[i].j_ready && stations[i].k_ready;
			if (ready[i])
				exec_idx = idx_width'(i);
		end
	end

	assign any_ready = |ready;
	assign station_busy = busy;

	always_ff @(posedge clk)
	begin
		cdb_out.tag <= stations[exec_idx].dest;
		cdb_out.data <= alu(stations[exec_idx]);
		for (int i = 0; i < `OOO_NUM_STATIONS; i++)
		begin
			if (station_write && station_sel[i])
				stations[i] <= station_issue;
			else
			begin
				// Snoop the bus for missing operands
				if (cdb_out.valid && !stations[i].j_ready && (stations[i].qj == cdb_out.tag))
				begin
					stations[i].vj <= cdb_out.data;
					stations[i].j_ready <= 1'b1;
				end
				if (cdb_out.valid && !stations[i].k_ready && (stations[i].qk == cdb_out.tag))
				begin
					stations[i].vk <= cdb_out.data;
					stations[i].k_ready <= 1'b1;
				end
			end
		end
		if (reset)
		begin
			busy <= '0;
			cdb_out.valid <= 1'b0;
		end
		else
		begin
			cdb_out.valid <= any_ready;
			for (int i = 0; i < `OOO_NUM_STATIONS; i++)
			begin
				if (any_ready && (exec_idx == idx_width'(i)))
					busy[i] <= 1'b0; // Freed as its result goes out
				if (station_write && station_sel[i])
					busy[i] <= 1'b1;
			end
		end
	end

endmodule : alu_stations

`default_nettype wire

// ==== src/reg_status_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ooo_consts.svh"

module reg_status_file
(
	input logic clk,
	input logic reset,
	input ooo_pkg::lc3b_reg sr1,
	input ooo_pkg::lc3b_reg sr2,
	output ooo_pkg::reg_status_t sr1_out,
	output ooo_pkg::reg_status_t sr2_out,
	input ooo_pkg::lc3b_reg reg_dest,
	input logic ld_reg_busy_dest,
	input ooo_pkg::lc3b_rob_addr reg_rob_entry,
	input logic commit_valid,
	input ooo_pkg::retire_t commit,
	input ooo_pkg::lc3b_rob_addr commit_tag
);

	import ooo_pkg::*;

	lc3b_word data [`OOO_NUM_REGS];
	lc3b_rob_addr writer [`OOO_NUM_REGS];
	logic [`OOO_NUM_REGS-1:0] busy;

	assign sr1_out = '{busy: busy[sr1], rob_entry: writer[sr1], data: data[sr1]};
	assign sr2_out = '{busy: busy[sr2], rob_entry: writer[sr2], data: data[sr2]};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= '0;
			for (int i = 0; i < `OOO_NUM_REGS; i++)
			begin
				data[i] <= '0;
				writer[i] <= '0;
			end
		end
		else
		begin
			if (commit_valid)
			begin
				data[commit.dest] <= commit.value;
				// A younger writer keeps the register busy
				if (writer[commit.dest] == commit_tag)
					busy[commit.dest] <= 1'b0;
			end
			if (ld_reg_busy_dest) // Issue overrides the retire clear
			begin
				busy[reg_dest] <= 1'b1;
				writer[reg_dest] <= reg_rob_entry;
			end
		end
	end

endmodule : reg_status_file

`default_nettype wire

// ==== src/issue_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ooo_consts.svh"

module issue_control
(
	input logic clk,
	input logic reset,
	input ooo_pkg::lc3b_word instr,
	input logic instr_valid,
	output logic instr_taken,
	input ooo_pkg::cdb_t cdb_in,
	input ooo_pkg::reg_status_t sr1_in,
	input ooo_pkg::reg_status_t sr2_in,
	output ooo_pkg::lc3b_reg sr1,
	output ooo_pkg::lc3b_reg sr2,
	output ooo_pkg::lc3b_reg reg_dest,
	output logic ld_reg_busy_dest,
	output ooo_pkg::lc3b_rob_addr reg_rob_entry,
	output ooo_pkg::lc3b_rob_addr rob_sr1_read_addr,
	output ooo_pkg::lc3b_rob_addr rob_sr2_read_addr,
	input ooo_pkg::lc3b_word rob_sr1_value_out,
	input ooo_pkg::lc3b_word rob_sr2_value_out,
	input logic rob_sr1_valid_out,
	input logic rob_sr2_valid_out,
	input logic rob_full,
	input ooo_pkg::lc3b_rob_addr rob_addr,
	output logic rob_write_enable,
	output ooo_pkg::rob_alloc_t rob_alloc,
	input logic [`OOO_NUM_STATIONS-1:0] station_busy,
	output logic station_write,
	output logic [`OOO_NUM_STATIONS-1:0] station_sel,
	output ooo_pkg::station_issue_t station_issue
);

	import ooo_pkg::*;

	lc3b_opcode opcode;
	lc3b_reg dest_reg;
	lc3b_word imm5;
	logic use_imm;
	logic j_ready, k_ready;
	lc3b_word vj, vk;
	lc3b_rob_addr qj, qk;

	// Register file first, then the CDB, then a finished ROB entry
	function automatic void resolve_operand(
		input reg_status_t status,
		input lc3b_word rob_value,
		input logic rob_valid,
		input cdb_t cdb,
		output logic ready,
		output lc3b_word value,
		output lc3b_rob_addr tag
	);
		ready = 1'b1;
		value = status.data;
		tag = '0;
		if (status.busy)
		begin
			if (cdb.valid && (cdb.tag == status.rob_entry))
				value = cdb.data;
			else if (rob_valid)
				value = rob_value;
			else
			begin
				ready = 1'b0; // Wait on the producer's tag
				value = '0;
				tag = status.rob_entry;
			end
		end
	endfunction

	assign opcode = lc3b_opcode'(instr[15:12]);
	assign dest_reg = instr[11:9];
	assign sr1 = instr[8:6];
	assign sr2 = instr[2:0];
	assign imm5 = {{11{instr[4]}}, instr[4:0]};
	assign use_imm = instr[5] || (opcode == op_not);

	assign rob_sr1_read_addr = sr1_in.rob_entry;
	assign rob_sr2_read_addr = sr2_in.rob_entry;

	// Lowest clear bit of the busy vector
	assign station_sel = ~station_busy & (station_busy + 1'b1);
	assign instr_taken = instr_valid && !rob_full && (station_sel != '0);

	always_comb
	begin
		resolve_operand(sr1_in, rob_sr1_value_out, rob_sr1_valid_out, cdb_in, j_ready, vj, qj);
		if (use_imm)
		begin
			k_ready = 1'b1;
			vk = imm5;
			qk = '0;
		end
		else
			resolve_operand(sr2_in, rob_sr2_value_out, rob_sr2_valid_out, cdb_in,
				k_ready, vk, qk);
	end

	assign station_write = instr_taken;
	assign station_issue = '{op: opcode, vj: vj, vk: vk, qj: qj, qk: qk,
		j_ready: j_ready, k_ready: k_ready, dest: rob_addr};

	assign rob_write_enable = instr_taken;
	assign rob_alloc = '{opcode: opcode, dest: dest_reg};

	// Rename the destination to the new ROB tag
	assign reg_dest = dest_reg;
	assign ld_reg_busy_dest = instr_taken;
	assign reg_rob_entry = rob_addr;

endmodule : issue_control

`default_nettype wire

// ==== src/instr_axil_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ooo_consts.svh"

module instr_axil_slave
(
	input logic clk,
	input logic reset,
	input logic awvalid,
	input logic [31:0] awaddr, // Ignored
	input logic wvalid,
	input ooo_pkg::lc3b_word wdata,
	output logic awready,
	output logic wready,
	output logic bvalid,
	output logic [1:0] bresp,
	input logic bready,
	output ooo_pkg::lc3b_word instr,
	output logic instr_valid,
	input logic instr_taken
);

	import ooo_pkg::*;

	localparam int ptr_width = $clog2(`OOO_QUEUE_DEPTH);
	localparam logic [ptr_width:0] queue_depth = `OOO_QUEUE_DEPTH;

	lc3b_word queue [`OOO_QUEUE_DEPTH];
	logic [ptr_width-1:0] head, tail;
	logic [ptr_width:0] count;
	lc3b_opcode wr_opcode;
	logic executable, handshake, push, pop;

	assign wr_opcode = lc3b_opcode'(wdata[15:12]);
	assign executable = (wr_opcode == op_add) || (wr_opcode == op_and) || (wr_opcode == op_not);
	assign handshake = awready && awvalid && wvalid;
	assign push = handshake && executable; // Refused words never enter the queue
	assign pop = instr_taken && instr_valid;

	assign wready = awready;
	assign instr = queue[head];
	assign instr_valid = (count != '0);

	always_ff @(posedge clk)
	begin
		if (push)
			queue[tail] <= wdata;
		if (reset)
		begin
			awready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= 2'b00;
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else
		begin
			// Single-cycle ready pulse, blocked while a response is pending
			awready <= awvalid && wvalid && !awready && !bvalid && (count != queue_depth);
			if (handshake)
			begin
				bvalid <= 1'b1;
				bresp <= executable ? 2'b00 : 2'b10; // OKAY or SLVERR
			end
			else if (bready)
				bvalid <= 1'b0;
			if (push)
				tail <= tail + 1'b1;
			if (pop)
				head <= head + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule : instr_axil_slave

`default_nettype wire

// ==== src/ooo_pkg.sv ====
`default_nettype none

`include "ooo_consts.svh"

package ooo_pkg;

	typedef logic [`OOO_DATA_WIDTH-1:0] lc3b_word;
	typedef logic [$clog2(`OOO_NUM_REGS)-1:0] lc3b_reg;
	typedef logic [`OOO_TAG_WIDTH-1:0] lc3b_rob_addr;

	// LC-3b opcode field, instr[15:12]
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001, // Executed
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101, // Executed
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001, // Executed
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef struct packed {
		logic valid;
		lc3b_rob_addr tag; // Producing ROB entry
		lc3b_word data;
	} cdb_t;

	typedef struct packed {
		logic busy;
		lc3b_rob_addr rob_entry; // Pending writer
		lc3b_word data;
	} reg_status_t;

	// One reservation station entry
	typedef struct packed {
		lc3b_opcode op;
		lc3b_word vj;
		lc3b_word vk;
		lc3b_rob_addr qj;
		lc3b_rob_addr qk;
		logic j_ready;
		logic k_ready;
		lc3b_rob_addr dest;
	} station_issue_t;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dest;
	} rob_alloc_t;

	typedef struct packed {
		lc3b_reg dest;
		lc3b_word value;
	} retire_t;

endpackage : ooo_pkg

`default_nettype wire

// ==== src/ooo_consts.svh ====
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// Datapath and tag widths
`define OOO_DATA_WIDTH 16
`define OOO_TAG_WIDTH 3

// Storage sizes
`define OOO_ROB_DEPTH 8
`define OOO_QUEUE_DEPTH 4
`define OOO_NUM_STATIONS 3
`define OOO_NUM_REGS 8

`endif
